// ==== project.f ====
rtl/core_pkg.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/lsu_apb.sv
rtl/core_ctrl.sv
rtl/core_top.sv
verif/core_assertions.sv
verif/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_core -o sim_core \
    && ./obj_dir/sim_core +verilator+error+limit+1000 | tee /dev/stderr \
    | grep -q "Result: PASSED" \
    && exit 0 \
    || exit 1

// ==== verif/tb_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core import core_pkg::*;;

    localparam int WATCHDOG_CYCLES = 4000;   // 200 instructions x 6 cycles plus margin

    logic     clk;
    logic     rst_n;
    word_t    inst;
    word_t    inst_addr;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     exit_flag;
    word_t    gp;

    word_t rom [0:255];
    word_t data_mem [0:255];
    word_t exp_alu [0:31];
    word_t exp_round;
    int    pc_w;
    int    n_alu;
    int    exp_markers;
    int    wait_left;
    int    draw;
    int    alu_seen;
    int    marker_seen;
    int    round_seen;
    int    tb_fails;

    core_top #(
        .EXIT_ADDR    (32'h44),
        .RESET_VECTOR (32'h0)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_i      (inst),
        .apb_rsp_i   (apb_rsp),
        .inst_addr_o (inst_addr),
        .apb_req_o   (apb_req),
        .exit_o      (exit_flag),
        .gp_o        (gp)
    );

    bind core_top core_assertions u_assertions (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .req_i   (apb_req_o),
        .rsp_i   (apb_rsp_i),
        .exit_i  (exit_o),
        .gp_i    (gp_o)
    );

    always #4 clk = ~clk;

    // RV32I instruction formats
    function automatic word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic word_t i_type(input int imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
        word_t v;
        v = imm;
        return {v[11:0], rs1, f3, rd, op};
    endfunction

    function automatic word_t s_type(input int imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1);
        word_t v;
        v = imm;
        return {v[11:5], rs2, rs1, 3'b010, v[4:0], 7'h23};
    endfunction

    function automatic word_t b_type(input int off, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
        word_t v;
        v = off;
        return {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], 7'h63};
    endfunction

    function automatic word_t j_type(input int off, input logic [4:0] rd);
        word_t v;
        v = off;
        return {v[20], v[10:1], v[11], v[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(input word_t w);
        rom[pc_w >> 2] = w;
        pc_w += 4;
    endtask

    // result register stored into the next checked slot
    task automatic store_checked(input logic [4:0] rs, input word_t expected);
        emit(s_type(32'h100 + 4 * n_alu, rs, 0));
        exp_alu[n_alu] = expected;
        n_alu++;
    endtask

    task automatic alu_case(input word_t w, input word_t expected);
        emit(w);
        store_checked(5, expected);
    endtask

    task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input logic taken);
        emit(b_type(8, rs2, rs1, f3));
        if (taken) begin
            emit(s_type(32'h200, 0, 0));   // skipped when taken
        end else begin
            emit(s_type(32'h1c0, 0, 0));
            exp_markers++;
        end
    endtask

    task automatic build_program();
        word_t a;
        word_t b;
        int    p;
        a = 32'hffff_ffec;   // -20
        b = 32'd7;
        emit(j_type(32'h80, 0));
        pc_w = 32'h80;
        emit(i_type(-20, 0, 3'b000, 1, 7'h13));
        emit(i_type(7, 0, 3'b000, 2, 7'h13));
        alu_case(r_type(7'h00, 2, 1, 3'b000, 5, 7'h33), a + b);
        alu_case(r_type(7'h20, 2, 1, 3'b000, 5, 7'h33), a - b);
        alu_case(r_type(7'h00, 2, 1, 3'b111, 5, 7'h33), a & b);
        alu_case(r_type(7'h00, 2, 1, 3'b110, 5, 7'h33), a | b);
        alu_case(r_type(7'h00, 2, 1, 3'b100, 5, 7'h33), a ^ b);
        alu_case(r_type(7'h00, 2, 1, 3'b001, 5, 7'h33), a << 7);
        alu_case(r_type(7'h00, 2, 1, 3'b101, 5, 7'h33), a >> 7);
        alu_case(r_type(7'h20, 2, 1, 3'b101, 5, 7'h33), word_t'($signed(a) >>> 7));
        alu_case(r_type(7'h00, 2, 1, 3'b010, 5, 7'h33), word_t'($signed(a) < $signed(b)));
        alu_case(r_type(7'h00, 2, 1, 3'b011, 5, 7'h33), word_t'(a < b));
        alu_case(i_type(-5, 1, 3'b000, 5, 7'h13), a - 32'd5);
        alu_case(i_type(32'hf0, 1, 3'b111, 5, 7'h13), a & 32'hf0);
        alu_case(i_type(32'h700, 2, 3'b110, 5, 7'h13), b | 32'h700);
        alu_case(i_type(-1, 1, 3'b100, 5, 7'h13), ~a);
        alu_case(i_type(28, 2, 3'b001, 5, 7'h13), b << 28);
        alu_case(i_type(4, 1, 3'b101, 5, 7'h13), a >> 4);
        alu_case(i_type(32'h402, 1, 3'b101, 5, 7'h13), word_t'($signed(a) >>> 2));
        alu_case(i_type(-1, 2, 3'b010, 5, 7'h13), word_t'($signed(b) < -1));
        alu_case(i_type(-1, 2, 3'b011, 5, 7'h13), word_t'(b < 32'hffff_ffff));
        alu_case({20'h12345, 5'd5, 7'h37}, 32'h1234_5000);
        p = pc_w;
        alu_case({20'h00001, 5'd5, 7'h17}, p + 32'h1000);
        // a < 0 < b splits signed and unsigned order
        branch_case(3'b000, 2, 2, 1'b1);
        branch_case(3'b000, 1, 2, 1'b0);
        branch_case(3'b001, 1, 2, 1'b1);
        branch_case(3'b001, 2, 2, 1'b0);
        branch_case(3'b100, 1, 2, 1'b1);
        branch_case(3'b100, 2, 1, 1'b0);
        branch_case(3'b101, 2, 1, 1'b1);
        branch_case(3'b101, 1, 2, 1'b0);
        branch_case(3'b110, 2, 1, 1'b1);
        branch_case(3'b110, 1, 2, 1'b0);
        branch_case(3'b111, 1, 2, 1'b1);
        branch_case(3'b111, 2, 1, 1'b0);
        p = pc_w;
        emit(j_type(8, 6));
        emit(s_type(32'h200, 0, 0));
        store_checked(6, p + 4);
        p = pc_w;
        emit({20'h0, 5'd7, 7'h17});                 // auipc x7, 0
        emit(i_type(17, 7, 3'b000, 6, 7'h67));      // odd offset loses bit 0
        emit(s_type(32'h200, 0, 0));
        emit(s_type(32'h200, 0, 0));
        store_checked(6, p + 8);
        emit(s_type(32'h180, 1, 0));
        exp_round = a + 32'd1;   // reloaded x1 plus one
        emit(i_type(32'h180, 0, 3'b010, 9, 7'h03));
        emit(i_type(1, 9, 3'b000, 9, 7'h13));
        emit(s_type(32'h184, 9, 0));
        emit(i_type(1, 0, 3'b000, 3, 7'h13));       // gp = 1 last
        p = pc_w;
        emit(j_type(32'h44 - p, 0));
        pc_w = 32'h44;
        emit(s_type(32'h200, 0, 0));   // parked here, never executed
    endtask

    always @(posedge clk) begin
        inst <= rom[inst_addr[9:2]];
    end

    // apb completer with 0 to 3 wait states per transfer
    always @(posedge clk) begin
        if (!rst_n) begin
            apb_rsp   <= '0;
            wait_left <= 0;
        end else if (apb_req.psel && apb_req.penable && apb_rsp.pready) begin
            if (apb_req.pwrite)
                data_mem[apb_req.paddr[9:2]] <= apb_req.pwdata;
            apb_rsp.pready <= 1'b0;
        end else if (apb_req.psel && !apb_req.penable) begin
            draw = $urandom % 4;
            wait_left      <= draw;
            apb_rsp.pready <= draw == 0;
            apb_rsp.prdata <= data_mem[apb_req.paddr[9:2]];
        end else if (apb_req.psel && apb_req.penable) begin
            if (wait_left <= 1)
                apb_rsp.pready <= 1'b1;
            wait_left <= wait_left - 1;
        end
    end

    always @(posedge clk) begin
        if (rst_n && apb_req.psel && apb_req.penable && apb_rsp.pready && apb_req.pwrite) begin
            if (apb_req.paddr >= 32'h100 && apb_req.paddr < 32'h180)
                alu_seen++;
            if (apb_req.paddr == 32'h1c0)
                marker_seen++;
            if (apb_req.paddr == 32'h184)
                round_seen++;
        end
    end

    task automatic check_count(input string name, input int expected, input int actual);
        if (expected != actual) begin
            tb_fails++;
            $display("error %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    initial begin
        int fails;
        void'($urandom(32'hd7f8_eb6f));
        clk         = 1'b0;
        rst_n       = 1'b0;
        inst        = '0;
        apb_rsp     = '0;
        pc_w        = 0;
        n_alu       = 0;
        exp_markers = 0;
        alu_seen    = 0;
        marker_seen = 0;
        round_seen  = 0;
        tb_fails    = 0;
        for (int i = 0; i < 256; i++) begin
            rom[i]      = '0;
            data_mem[i] = (i << 2) ^ 32'hc3c3_0000;
        end
        build_program();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        do @(negedge clk); while (!exit_flag);
        repeat (8) @(negedge clk);
        $display("apb protocol: checked from reset release to %0t", $time);
        check_count("alu_store_count", n_alu, alu_seen);
        $display("alu results: %0d stores seen", alu_seen);
        check_count("branch_marker_count", exp_markers, marker_seen);
        $display("branches and jumps: %0d markers seen", marker_seen);
        check_count("round_trip_store_count", 1, round_seen);
        $display("load/store round trip: %0d second stores seen", round_seen);
        $display("exit reached, gp_o = %0d", gp);
        fails = tb_fails + u_dut.u_assertions.fail_count;
        $display("tests: 5, failed checks: %0d", fails);
        if (fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: core never reached exit within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/core_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_assertions import core_pkg::*; (
    input wire logic     clk_i,
    input wire logic     rst_n_i,
    input wire apb_req_t req_i,
    input wire apb_rsp_t rsp_i,
    input wire logic     exit_i,
    input wire word_t    gp_i
);

    localparam word_t ALU_BASE    = 32'h100;
    localparam word_t ALU_END     = 32'h180;
    localparam word_t ROUND_NEXT  = 32'h184;
    localparam word_t FORBID_ADDR = 32'h200;

    int   fail_count = 0;
    logic wr_done;

    assign wr_done = req_i.psel && req_i.penable && rsp_i.pready && req_i.pwrite;

    setup_then_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i.psel && !req_i.penable |=> req_i.psel && req_i.penable)
    else begin
        fail_count++;
        $error("setup cycle at %0t was not followed by an access cycle", $time);
    end

    // payload held until the completing access cycle
    payload_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i.psel && !(req_i.penable && rsp_i.pready) |=>
            $stable(req_i.paddr) && $stable(req_i.pwrite) && $stable(req_i.pwdata))
    else begin
        fail_count++;
        $error("apb address, direction or write data changed before completion at %0t", $time);
    end

    idle_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !req_i.psel && !req_i.penable)
    else begin
        fail_count++;
        $error("psel or penable high in the first cycle after reset at %0t", $time);
    end

    alu_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr_done && req_i.paddr >= ALU_BASE && req_i.paddr < ALU_END |->
            req_i.pwdata == tb_core.exp_alu[req_i.paddr[6:2]])
    else begin
        fail_count++;
        $error("error %0t pwdata expected %h actual %h", $time,
               tb_core.exp_alu[$sampled(req_i.paddr[6:2])], $sampled(req_i.pwdata));
    end

    no_wrong_path: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i.psel && req_i.pwrite |-> req_i.paddr != FORBID_ADDR)
    else begin
        fail_count++;
        $error("store on a wrong branch or jump path reached the bus at %0t", $time);
    end

    round_trip: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr_done && req_i.paddr == ROUND_NEXT |->
            req_i.pwdata == tb_core.exp_round)
    else begin
        fail_count++;
        $error("error %0t pwdata expected %h actual %h", $time,
               tb_core.exp_round, $sampled(req_i.pwdata));
    end

    exit_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        exit_i |=> exit_i)
    else begin
        fail_count++;
        $error("exit dropped after it was raised at %0t", $time);
    end

    quiet_after_exit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        exit_i |-> !req_i.psel)
    else begin
        fail_count++;
        $error("apb transfer started after exit at %0t", $time);
    end

    gp_at_exit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(exit_i) |-> gp_i == 32'd1)
    else begin
        fail_count++;
        $error("error %0t gp_o expected %h actual %h", $time, 32'd1, $sampled(gp_i));
    end

endmodule

`default_nettype wire

// ==== rtl/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*; #(
    parameter word_t EXIT_ADDR    = 32'h44,
    parameter word_t RESET_VECTOR = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    inst_i,
    input  apb_rsp_t apb_rsp_i,
    output word_t    inst_addr_o,
    output apb_req_t apb_req_o,
    output logic     exit_o,
    output word_t    gp_o
);

    ctrl_t     ctrl;
    word_t     pc;
    reg_addr_t rs1_addr, rs2_addr;
    word_t     rs1_data, rs2_data;
    word_t     alu_out;
    logic      br_taken;
    logic      mem_start, mem_done;
    word_t     mem_rdata;
    logic      rf_wen;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    assign inst_addr_o = pc;   // rom answers one clock later

    inst_decoder u_decoder (
        .inst_i     (inst_i),
        .pc_i       (pc),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .ctrl_o     (ctrl)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .waddr_i  (rf_waddr),
        .wen_i    (rf_wen),
        .wdata_i  (rf_wdata),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .gp_o     (gp_o)
    );

    alu u_alu (
        .alu_op_i   (ctrl.alu_op),
        .op1_i      (ctrl.op1),
        .op2_i      (ctrl.op2),
        .alu_out_o  (alu_out),
        .br_taken_o (br_taken)
    );

    lsu_apb u_lsu (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (mem_start),
        .ctrl_i    (ctrl),
        .addr_i    (alu_out),
        .apb_rsp_i (apb_rsp_i),
        .apb_req_o (apb_req_o),
        .done_o    (mem_done),
        .rdata_o   (mem_rdata)
    );

    core_ctrl #(
        .EXIT_ADDR    (EXIT_ADDR),
        .RESET_VECTOR (RESET_VECTOR)
    ) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl_i      (ctrl),
        .alu_out_i   (alu_out),
        .br_taken_i  (br_taken),
        .mem_done_i  (mem_done),
        .mem_rdata_i (mem_rdata),
        .pc_o        (pc),
        .mem_start_o (mem_start),
        .rf_wen_o    (rf_wen),
        .rf_waddr_o  (rf_waddr),
        .rf_wdata_o  (rf_wdata),
        .exit_o      (exit_o)
    );

endmodule

`default_nettype wire

// ==== rtl/core_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_ctrl import core_pkg::*; #(
    parameter word_t EXIT_ADDR    = 32'h44,
    parameter word_t RESET_VECTOR = '0
) (
    input  logic      clk,
    input  logic      rst_n,
    input  ctrl_t     ctrl_i,
    input  word_t     alu_out_i,
    input  logic      br_taken_i,
    input  logic      mem_done_i,
    input  word_t     mem_rdata_i,
    output word_t     pc_o,
    output logic      mem_start_o,
    output logic      rf_wen_o,
    output reg_addr_t rf_waddr_o,
    output word_t     rf_wdata_o,
    output logic      exit_o
);

    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_mem
    } state_e;

    state_e state_q;
    word_t  pc_q;
    word_t  pc_plus4;
    word_t  next_pc;
    logic   exit_q;
    logic   exit_hit;
    logic   is_mem;
    logic   retire;

    assign pc_plus4 = pc_q + 32'd4;
    assign exit_hit = pc_q == EXIT_ADDR;
    assign is_mem   = ctrl_i.is_load || ctrl_i.is_store;

    // non-memory ops finish in execute, lw/sw when the bus completes
    assign retire = (state_q == st_execute && !is_mem) || (state_q == st_mem && mem_done_i);

    always_comb begin
        if (ctrl_i.illegal)
            next_pc = pc_plus4;
        else if (ctrl_i.is_branch && br_taken_i)
            next_pc = ctrl_i.branch_target;
        else if (ctrl_i.is_jump)
            next_pc = alu_out_i;   // jal sum or jalr with bit 0 cleared
        else
            next_pc = pc_plus4;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_fetch;
            pc_q    <= RESET_VECTOR;
            exit_q  <= 1'b0;
        end else begin
            exit_q <= exit_q || exit_hit;   // sticky
            case (state_q)
                st_fetch: begin
                    if (!exit_hit)   // parked at the exit address
                        state_q <= st_execute;
                end
                st_execute: begin
                    state_q <= is_mem ? st_mem : st_fetch;
                end
                default: begin
                    if (mem_done_i)
                        state_q <= st_fetch;
                end
            endcase
            if (retire)
                pc_q <= next_pc;
        end
    end

    assign pc_o        = pc_q;
    assign exit_o      = exit_q;
    assign mem_start_o = state_q == st_execute && is_mem;

    assign rf_wen_o   = retire && ctrl_i.rf_wen && !ctrl_i.illegal;
    assign rf_waddr_o = ctrl_i.wb_addr;

    always_comb begin
        case (ctrl_i.wb_sel)
            wb_mem:      rf_wdata_o = mem_rdata_i;
            wb_pc_plus4: rf_wdata_o = pc_plus4;
            default:     rf_wdata_o = alu_out_i;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/lsu_apb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_apb import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start_i,
    input  ctrl_t    ctrl_i,
    input  word_t    addr_i,
    input  apb_rsp_t apb_rsp_i,
    output apb_req_t apb_req_o,
    output logic     done_o,
    output word_t    rdata_o
);

    typedef enum logic {
        lsu_setup,    // idle, setup driven while start_i is high
        lsu_access
    } lsu_state_e;

    lsu_state_e state_q;
    word_t      addr_q;
    word_t      wdata_q;
    logic       write_q;
    logic       in_access;

    assign in_access = state_q == lsu_access;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= lsu_setup;
        end else if (!in_access && start_i) begin
            state_q <= lsu_access;
        end else if (in_access && apb_rsp_i.pready) begin
            state_q <= lsu_setup;
        end
    end

    // transfer payload, held from setup to completion
    always_ff @(posedge clk) begin
        if (!in_access && start_i) begin
            addr_q  <= addr_i;
            write_q <= ctrl_i.is_store;
            wdata_q <= ctrl_i.store_data;
        end
    end

    assign apb_req_o.psel    = in_access || start_i;
    assign apb_req_o.penable = in_access;
    assign apb_req_o.pwrite  = in_access ? write_q : ctrl_i.is_store;
    assign apb_req_o.paddr   = in_access ? addr_q : addr_i;
    assign apb_req_o.pwdata  = in_access ? wdata_q : ctrl_i.store_data;

    assign done_o  = in_access && apb_rsp_i.pready;
    assign rdata_o = apb_rsp_i.prdata;   // valid with done_o

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import core_pkg::*; (
    input  alu_op_e alu_op_i,
    input  word_t   op1_i,
    input  word_t   op2_i,
    output word_t   alu_out_o,
    output logic    br_taken_o
);

    logic eq, lt_s, lt_u;
    word_t sum;

    assign sum  = op1_i + op2_i;
    assign eq   = op1_i == op2_i;
    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;

    always_comb begin
        case (alu_op_i)
            alu_add:      alu_out_o = sum;
            alu_sub:      alu_out_o = op1_i - op2_i;
            alu_and:      alu_out_o = op1_i & op2_i;
            alu_or:       alu_out_o = op1_i | op2_i;
            alu_xor:      alu_out_o = op1_i ^ op2_i;
            alu_sll:      alu_out_o = op1_i << op2_i[4:0];
            alu_srl:      alu_out_o = op1_i >> op2_i[4:0];
            alu_sra:      alu_out_o = $signed(op1_i) >>> op2_i[4:0];
            alu_slt:      alu_out_o = {{(WORD_LEN-1){1'b0}}, lt_s};
            alu_sltu:     alu_out_o = {{(WORD_LEN-1){1'b0}}, lt_u};
            alu_jalr_add: alu_out_o = {sum[WORD_LEN-1:1], 1'b0};
            default:      alu_out_o = '0;   // branches and none
        endcase
    end

    always_comb begin
        case (alu_op_i)
            br_beq:  br_taken_o = eq;
            br_bne:  br_taken_o = !eq;
            br_blt:  br_taken_o = lt_s;
            br_bge:  br_taken_o = !lt_s;
            br_bltu: br_taken_o = lt_u;
            br_bgeu: br_taken_o = !lt_u;
            default: br_taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    input  reg_addr_t waddr_i,
    input  logic      wen_i,
    input  word_t     wdata_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o,
    output word_t     gp_o
);

    word_t regs [1:REG_COUNT-1];   // no storage behind x0

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

    assign gp_o = regs[3];

endmodule

`default_nettype wire

// ==== rtl/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import core_pkg::*; (
    input  word_t     inst_i,
    input  word_t     pc_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output ctrl_t     ctrl_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i, imm_s, imm_b, imm_j, imm_u;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};

    // shared by op and op_imm, alt picks sub / sra
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    always_comb begin
        ctrl_o               = '0;
        ctrl_o.alu_op        = alu_none;
        ctrl_o.op1           = rs1_data_i;
        ctrl_o.op2           = rs2_data_i;
        ctrl_o.store_data    = rs2_data_i;
        ctrl_o.branch_target = pc_i + imm_b;
        ctrl_o.wb_sel        = wb_alu;
        ctrl_o.wb_addr       = inst_i[11:7];

        case (opcode)
            opc_op: begin
                ctrl_o.rf_wen = 1'b1;
                if (funct7 == 7'h00 || (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)))
                    ctrl_o.alu_op = arith_op(funct3, funct7[5]);
                else
                    ctrl_o.illegal = 1'b1;
            end
            opc_op_imm: begin
                ctrl_o.rf_wen = 1'b1;
                ctrl_o.op2    = imm_i;
                ctrl_o.alu_op = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
                if (funct3 == 3'b001 && funct7 != 7'h00)
                    ctrl_o.illegal = 1'b1;
                if (funct3 == 3'b101 && funct7 != 7'h00 && funct7 != 7'h20)
                    ctrl_o.illegal = 1'b1;
            end
            opc_load: begin   // lw only
                ctrl_o.alu_op  = alu_add;
                ctrl_o.op2     = imm_i;
                ctrl_o.is_load = 1'b1;
                ctrl_o.wb_sel  = wb_mem;
                ctrl_o.rf_wen  = 1'b1;
                ctrl_o.illegal = funct3 != 3'b010;
            end
            opc_store: begin  // sw only
                ctrl_o.alu_op   = alu_add;
                ctrl_o.op2      = imm_s;
                ctrl_o.is_store = 1'b1;
                ctrl_o.illegal  = funct3 != 3'b010;
            end
            opc_branch: begin
                ctrl_o.is_branch = 1'b1;
                case (funct3)
                    3'b000:  ctrl_o.alu_op = br_beq;
                    3'b001:  ctrl_o.alu_op = br_bne;
                    3'b100:  ctrl_o.alu_op = br_blt;
                    3'b101:  ctrl_o.alu_op = br_bge;
                    3'b110:  ctrl_o.alu_op = br_bltu;
                    3'b111:  ctrl_o.alu_op = br_bgeu;
                    default: ctrl_o.illegal = 1'b1;
                endcase
            end
            opc_jal: begin
                ctrl_o.alu_op  = alu_add;
                ctrl_o.op1     = pc_i;
                ctrl_o.op2     = imm_j;
                ctrl_o.is_jump = 1'b1;
                ctrl_o.wb_sel  = wb_pc_plus4;
                ctrl_o.rf_wen  = 1'b1;
            end
            opc_jalr: begin
                ctrl_o.alu_op  = alu_jalr_add;
                ctrl_o.op2     = imm_i;
                ctrl_o.is_jump = 1'b1;
                ctrl_o.wb_sel  = wb_pc_plus4;
                ctrl_o.rf_wen  = 1'b1;
                ctrl_o.illegal = funct3 != 3'b000;
            end
            opc_lui: begin
                ctrl_o.alu_op = alu_add;
                ctrl_o.op1    = '0;
                ctrl_o.op2    = imm_u;
                ctrl_o.rf_wen = 1'b1;
            end
            opc_auipc: begin
                ctrl_o.alu_op = alu_add;
                ctrl_o.op1    = pc_i;
                ctrl_o.op2    = imm_u;
                ctrl_o.rf_wen = 1'b1;
            end
            default: ctrl_o.illegal = 1'b1;
        endcase

        // an illegal word retires with no side effects
        if (ctrl_o.illegal) begin
            ctrl_o.alu_op    = alu_none;
            ctrl_o.rf_wen    = 1'b0;
            ctrl_o.is_load   = 1'b0;
            ctrl_o.is_store  = 1'b0;
            ctrl_o.is_jump   = 1'b0;
            ctrl_o.is_branch = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int WORD_LEN     = 32;
    localparam int REG_ADDR_LEN = 5;
    localparam int REG_COUNT    = 2 ** REG_ADDR_LEN;

    typedef logic [WORD_LEN-1:0]     word_t;
    typedef logic [REG_ADDR_LEN-1:0] reg_addr_t;

    // RV32I major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111
    } opcode_e;

    typedef enum logic [4:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu,
        alu_jalr_add,
        br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu,
        alu_none
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc_plus4
    } wb_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;
        word_t     op1;
        word_t     op2;
        word_t     store_data;
        word_t     branch_target;
        wb_sel_e   wb_sel;
        reg_addr_t wb_addr;
        logic      rf_wen;
        logic      is_load;
        logic      is_store;
        logic      is_jump;
        logic      is_branch;
        logic      illegal;
    } ctrl_t;

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        word_t paddr;
        word_t pwdata;
    } apb_req_t;

    typedef struct packed {
        logic  pready;
        word_t prdata;
    } apb_rsp_t;

endpackage

`default_nettype wire
